// File: uart_apb.f
+incdir+.
uart_reg_pkg.sv
uart_line_pkg.sv
uart_tx.sv
uart_rx.sv
uart_regs.sv
uart_apb.sv
tb_uart_apb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the uart testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f uart_apb.f \
    --top-module tb_uart_apb -o tb_uart_apb || { echo "build failed"; exit 1; }

./obj_dir/tb_uart_apb | tee /dev/stderr | grep -F "All tests passed!" > /dev/null \
    && echo "simulation result: pass" \
    || { echo "simulation result: fail"; exit 1; }

// File: tb_uart_apb.sv
`timescale 1ns/1ns
`include "uart_defs.svh"

module tb_uart_apb import uart_reg_pkg::*; ();

    localparam int DIV         = 3;                        // divisor under test
    localparam int BIT_CLKS    = DIV * `UART_OVERSAMPLE;   // clocks per serial bit
    localparam int N_FRAMES    = 52;                       // tx 20, rx 20, err 3, loop 6, irq 3
    localparam int FRAME_NS    = 10 * BIT_CLKS * 20;
    localparam int WATCHDOG_NS = N_FRAMES * FRAME_NS * 3 / 2 + 200000;
    localparam int POLL_MAX    = 8 * BIT_CLKS;             // lsr reads, 3 clocks each

    logic                    clk, nreset;
    logic [`UART_ADDR_W-1:0] paddr;
    logic                    psel, penable, pwrite;
    logic [31:0]             pwdata, prdata;
    logic                    pready, rxd_in, txd_out, irq;

    integer     seed, val_errs, other_errs;
    logic       loop_chk;      // txd_out must stay idle
    uart_byte_t tx_exp_q[$];   // bytes written to thr
    uart_byte_t tx_got_q[$];   // bytes decoded off txd_out

    uart_apb i_dut (.clk, .nreset, .paddr, .psel, .penable, .pwrite, .pwdata,
                    .prdata, .pready, .rxd_in, .txd_out, .irq);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // apb and line tasks
    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        val_errs++;
        $display("** Error: %s = 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
    endtask

    task automatic apb_write(input uart_reg_e off, input uart_byte_t data);
        @(negedge clk);
        paddr   = {{(`UART_ADDR_W-5){1'b0}}, off, 2'b00};
        pwdata  = {24'b0, data};
        pwrite  = 1'b1;
        psel    = 1'b1;   // setup
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;   // access, write lands on next edge
        @(negedge clk);
        if (pready !== 1'b1)
            report_mismatch("pready", {31'b0, pready}, 32'h1);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input uart_reg_e off, output logic [31:0] data);
        @(negedge clk);
        paddr   = {{(`UART_ADDR_W-5){1'b0}}, off, 2'b00};
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);   // prdata captured at setup edge
        penable = 1'b1;
        @(negedge clk);
        data    = prdata;
        if (pready !== 1'b1)
            report_mismatch("pready", {31'b0, pready}, 32'h1);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic expect_reg(input uart_reg_e off, input logic [31:0] exp, input string name);
        logic [31:0] rd;
        apb_read(off, rd);
        if (rd !== exp)
            report_mismatch(name, rd, exp);
    endtask

    // read lsr until all mask bits are set
    task automatic poll_lsr(input uart_byte_t mask, input string what);
        logic [31:0] rd;
        integer      n;
        n  = 0;
        rd = '0;
        while ((rd[7:0] & mask) != mask && n < POLL_MAX) begin
            apb_read(LS, rd);
            n++;
        end
        if ((rd[7:0] & mask) != mask) begin
            other_errs++;
            $display("%s never came up in LSR at %0t ns", what, $time);
        end
    endtask

    task automatic wait_irq;
        integer n;
        n = 0;
        while (irq !== 1'b1 && n < POLL_MAX) begin
            @(negedge clk);
            n++;
        end
        if (irq !== 1'b1) begin
            other_errs++;
            $display("irq did not rise at %0t ns", $time);
        end
    endtask

    // 8n1 frame onto rxd_in
    task automatic send_frame(input uart_byte_t data, input logic stop_ok);
        integer i;
        @(negedge clk);
        rxd_in = 1'b0;
        repeat (BIT_CLKS) @(negedge clk);
        for (i = 0; i < `UART_DATA_W; i++) begin
            rxd_in = data[i];   // lsb first
            repeat (BIT_CLKS) @(negedge clk);
        end
        rxd_in = stop_ok;
        // bad stop cut short so it is not taken for a new start bit
        repeat (stop_ok ? BIT_CLKS : BIT_CLKS * 3 / 4) @(negedge clk);
        rxd_in = 1'b1;
        repeat (stop_ok ? BIT_CLKS : BIT_CLKS * 5 / 4) @(negedge clk);  // idle gap
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // line monitor, decodes txd_out mid-bit
    initial begin : tx_monitor
        uart_byte_t b;
        integer     i;
        wait (nreset === 1'b1);
        forever begin
            @(negedge txd_out);
            repeat (BIT_CLKS / 2) @(negedge clk);
            if (txd_out !== 1'b0)
                report_mismatch("txd_out start bit", {31'b0, txd_out}, 32'h0);
            for (i = 0; i < `UART_DATA_W; i++) begin
                repeat (BIT_CLKS) @(negedge clk);
                b[i] = txd_out;
            end
            repeat (BIT_CLKS) @(negedge clk);
            if (txd_out !== 1'b1)
                report_mismatch("txd_out stop bit", {31'b0, txd_out}, 32'h1);
            tx_got_q.push_back(b);
        end
    end

    initial begin : loopback_pin_watch
        forever begin
            @(negedge clk);
            if (loop_chk && txd_out !== 1'b1) begin
                report_mismatch("txd_out in loopback", {31'b0, txd_out}, 32'h1);
                loop_chk = 1'b0;  // one report is enough
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired, tests did not finish in time");
        $display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
        $display("Test failures found");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    initial begin : main
        integer     i, n;
        uart_byte_t r, r2;
        seed = 80225;
        val_errs = 0;
        other_errs = 0;
        loop_chk = 1'b0;
        nreset = 1'b0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        rxd_in = 1'b1;   // idle line
        repeat (10) @(negedge clk);
        nreset = 1'b1;

        // reset values, then readback
        expect_reg(LC, 32'h03, "prdata LCR reset");
        expect_reg(LS, 32'h60, "prdata LSR reset");
        expect_reg(II, 32'hC1, "prdata IIR reset");
        for (i = 0; i < 4; i++) begin
            r = uart_byte_t'($random(seed));
            apb_write(SR, r);
            expect_reg(SR, {24'b0, r}, "prdata SCR");
            apb_write(LC, r);
            expect_reg(LC, {24'b0, r}, "prdata LCR");
            apb_write(LC, 8'h83);   // dlab
            apb_write(IE_DLM, r);
            expect_reg(IE_DLM, {24'b0, r}, "prdata DLM");
            apb_write(RB_TH_DLL, ~r);
            expect_reg(RB_TH_DLL, {24'b0, ~r}, "prdata DLL");
            apb_write(LC, 8'h03);
            apb_write(IE_DLM, r);
            expect_reg(IE_DLM, {29'b0, r[2:0]}, "prdata IER");  // 3 enables only
            apb_write(MC, r);
            expect_reg(MC, {27'b0, r[4], 4'b0}, "prdata MCR");  // loopback bit only
        end
        apb_write(MC, 8'h00);
        apb_write(IE_DLM, 8'h00);
        apb_write(LC, 8'h83);
        apb_write(IE_DLM, 8'h00);              // dlm first, dll write reloads
        apb_write(RB_TH_DLL, uart_byte_t'(DIV));
        apb_write(LC, 8'h03);

        // transmit
        for (i = 0; i < 20; i++) begin
            poll_lsr(8'h20, "THRE");
            r = uart_byte_t'($random(seed));
            tx_exp_q.push_back(r);
            apb_write(RB_TH_DLL, r);
        end
        n = 0;
        while (tx_got_q.size() < 20 && n < 3 * 10 * BIT_CLKS) begin
            @(negedge clk);
            n++;
        end
        if (tx_got_q.size() != 20) begin
            other_errs++;
            $display("only %0d of 20 frames seen on txd_out", tx_got_q.size());
        end
        poll_lsr(8'h40, "TEMT");
        for (i = 0; i < tx_got_q.size() && i < tx_exp_q.size(); i++)
            if (tx_got_q[i] !== tx_exp_q[i])
                report_mismatch("txd_out frame data", {24'b0, tx_got_q[i]}, {24'b0, tx_exp_q[i]});

        // receive
        for (i = 0; i < 20; i++) begin
            r = uart_byte_t'($random(seed));
            send_frame(r, 1'b1);
            poll_lsr(8'h01, "DR");
            expect_reg(RB_TH_DLL, {24'b0, r}, "prdata RBR");
            expect_reg(LS, 32'h60, "prdata LSR after RBR read");
        end

        // overrun then framing error
        r  = uart_byte_t'($random(seed));
        r2 = uart_byte_t'($random(seed));
        send_frame(r, 1'b1);
        send_frame(r2, 1'b1);
        expect_reg(LS, 32'h63, "prdata LSR overrun");
        expect_reg(LS, 32'h61, "prdata LSR after clear");
        expect_reg(RB_TH_DLL, {24'b0, r2}, "prdata RBR overrun");
        r = uart_byte_t'($random(seed));
        send_frame(r, 1'b0);
        expect_reg(LS, 32'h69, "prdata LSR framing");
        expect_reg(LS, 32'h61, "prdata LSR after clear");
        expect_reg(RB_TH_DLL, {24'b0, r}, "prdata RBR framing");
        expect_reg(LS, 32'h60, "prdata LSR idle");

        // loopback
        apb_write(MC, 8'h10);
        loop_chk = 1'b1;
        for (i = 0; i < 6; i++) begin
            poll_lsr(8'h20, "THRE");
            r = uart_byte_t'($random(seed));
            apb_write(RB_TH_DLL, r);
            poll_lsr(8'h01, "DR");
            expect_reg(RB_TH_DLL, {24'b0, r}, "prdata RBR loopback");
        end
        poll_lsr(8'h40, "TEMT");
        loop_chk = 1'b0;
        apb_write(MC, 8'h00);

        // interrupts, rda
        if (irq !== 1'b0)
            report_mismatch("irq", {31'b0, irq}, 32'h0);
        apb_write(IE_DLM, 8'h01);
        r = uart_byte_t'($random(seed));
        send_frame(r, 1'b1);
        wait_irq;
        expect_reg(II, 32'hC4, "prdata IIR rda");
        expect_reg(RB_TH_DLL, {24'b0, r}, "prdata RBR");
        repeat (2) @(negedge clk);   // dr clear, then irq register
        if (irq !== 1'b0)
            report_mismatch("irq", {31'b0, irq}, 32'h0);

        // thre, acked by the iir read
        apb_write(IE_DLM, 8'h02);
        wait_irq;
        expect_reg(II, 32'hC2, "prdata IIR thre");
        repeat (2) @(negedge clk);
        if (irq !== 1'b0)
            report_mismatch("irq", {31'b0, irq}, 32'h0);
        expect_reg(II, 32'hC1, "prdata IIR none");

        // line status over rda
        apb_write(IE_DLM, 8'h05);
        r  = uart_byte_t'($random(seed));
        r2 = uart_byte_t'($random(seed));
        send_frame(r, 1'b1);
        send_frame(r2, 1'b1);
        expect_reg(II, 32'hC6, "prdata IIR rls");
        expect_reg(LS, 32'h63, "prdata LSR overrun");
        expect_reg(II, 32'hC4, "prdata IIR rda");
        expect_reg(RB_TH_DLL, {24'b0, r2}, "prdata RBR");
        expect_reg(II, 32'hC1, "prdata IIR none");
        apb_write(IE_DLM, 8'h00);

        $display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: uart_apb.sv
`timescale 1ns/1ns
`include "uart_defs.svh"

module uart_apb import uart_reg_pkg::*; (
    input  logic                    clk,
    input  logic                    nreset,
    // apb slave
    input  logic [`UART_ADDR_W-1:0] paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    // serial pins
    input  logic                    rxd_in,
    output logic                    txd_out,
    output logic                    irq
);

    // between register block and line modules
    logic       baud_tick;
    logic       tx_load;
    logic       tx_serial;
    logic       tx_busy;
    logic       rx_serial;
    logic       rx_valid;
    logic       rx_frame_err;
    uart_byte_t tx_data;
    uart_byte_t rx_data;

    assign pready = 1'b1;  // zero wait states

    // registers, baud gen, status and irq
    uart_regs i_regs (.*);

    // tx and rx run side by side off the same tick
    uart_tx i_tx (.*);

    uart_rx i_rx (.*);

endmodule

// File: uart_regs.sv
`timescale 1ns/1ns
`include "uart_defs.svh"

module uart_regs import uart_reg_pkg::*; (
    input  logic                    clk,
    input  logic                    nreset,
    input  logic [`UART_ADDR_W-1:0] paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    input  logic                    rxd_in,
    output logic                    txd_out,
    output logic                    irq,
    output logic                    baud_tick,  // to both line modules
    output logic                    tx_load,
    output uart_byte_t              tx_data,
    output logic                    rx_serial,
    input  logic                    tx_serial,
    input  logic                    tx_busy,
    input  logic                    rx_valid,
    input  logic                    rx_frame_err,
    input  uart_byte_t              rx_data
);

    uart_byte_t lcr, scratch, thr, rbr, wbyte, lsr, rd_byte;
    uart_div_t  dl, dlc;
    logic [2:0] ier;  // rls, thre, rda
    uart_reg_e  reg_off;
    uart_iir_e  iir_code;
    logic       reg_read, reg_write, addr_valid, dlab, loopback;
    logic       wr_thr, wr_dll, rd_rbr, rd_lsr, rd_iir, dl_reload;
    logic       thr_full, dr, oe, fe, rbr_pop, thre, temt;
    logic       thre_int, thre_int_d, thre_pnd;
    logic       rxd_meta, rxd_sync;

    ////////////////////////////////////////////////////////////////////////////
    // apb decode, read in setup phase and write in access phase
    assign reg_read   = psel && !penable && !pwrite;
    assign reg_write  = psel && penable && pwrite;
    assign reg_off    = uart_reg_e'(paddr[4:2]);
    assign addr_valid = (paddr[`UART_ADDR_W-1:5] == '0) && (paddr[4:2] != 3'd6);
    assign wbyte      = pwdata[`UART_DATA_W-1:0];
    assign dlab       = lcr[7];

    assign wr_thr = reg_write && addr_valid && reg_off == RB_TH_DLL && !dlab;
    assign wr_dll = reg_write && addr_valid && reg_off == RB_TH_DLL && dlab;
    assign rd_rbr = reg_read && addr_valid && reg_off == RB_TH_DLL && !dlab;
    assign rd_lsr = reg_read && addr_valid && reg_off == LS;
    assign rd_iir = reg_read && addr_valid && reg_off == II;

    // config registers
    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            lcr      <= `UART_LCR_RESET;  // 8n1
            ier      <= '0;
            loopback <= 1'b0;
            scratch  <= '0;
            dl       <= '0;  // no ticks until programmed
        end else if (reg_write && addr_valid) begin
            case (reg_off)
                RB_TH_DLL: begin
                    if (dlab)
                        dl[`UART_DATA_W-1:0] <= wbyte;
                end
                IE_DLM: begin
                    if (dlab)
                        dl[`UART_DIV_W-1:`UART_DATA_W] <= wbyte;
                    else
                        ier <= wbyte[2:0];
                end
                LC:      lcr      <= wbyte;
                MC:      loopback <= wbyte[4];
                SR:      scratch  <= wbyte;
                default: ;  // iir and lsr are read only
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // transmit holding register
    always_ff @(posedge clk) begin
        if (wr_thr)
            thr <= wbyte;  // overwrites if still full
    end

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            thr_full <= 1'b0;
            tx_load  <= 1'b0;
        end else begin
            tx_load <= thr_full && !tx_busy && !tx_load;
            if (wr_thr)
                thr_full <= 1'b1;
            else if (tx_load)
                thr_full <= 1'b0;  // shifter took it
        end
    end

    assign tx_data = thr;
    assign thre    = !thr_full;
    assign temt    = thre && !tx_busy;

    // 16x baud tick, reloaded after a dll write
    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            dlc       <= '0;
            dl_reload <= 1'b0;
            baud_tick <= 1'b0;
        end else begin
            dl_reload <= wr_dll;  // dl holds the new value next cycle
            baud_tick <= (dl != '0) && (dlc == '0) && !dl_reload;
            if (dl_reload || dlc == '0)
                dlc <= dl - 1'b1;
            else
                dlc <= dlc - 1'b1;
        end
    end

    // rxd synchronizer and loopback
    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            rxd_meta <= 1'b1;  // idle line
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd_in;
            rxd_sync <= rxd_meta;
        end
    end

    assign rx_serial = loopback ? tx_serial : rxd_sync;
    assign txd_out   = loopback ? 1'b1 : tx_serial;  // pin held idle in loopback

    ////////////////////////////////////////////////////////////////////////////
    // receive buffer and line status
    always_ff @(posedge clk) begin
        if (rx_valid)
            rbr <= rx_data;
    end

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            rbr_pop <= 1'b0;
            dr      <= 1'b0;
            oe      <= 1'b0;
            fe      <= 1'b0;
        end else begin
            rbr_pop <= rd_rbr;  // clear dr after prdata captured
            if (rx_valid)
                dr <= 1'b1;
            else if (rbr_pop)
                dr <= 1'b0;
            if (rx_valid && dr && !rbr_pop)
                oe <= 1'b1;  // unread byte lost
            else if (rd_lsr)
                oe <= 1'b0;
            if (rx_valid && rx_frame_err)
                fe <= 1'b1;
            else if (rd_lsr)
                fe <= 1'b0;
        end
    end

    assign lsr = {1'b0, temt, thre, 1'b0, fe, 1'b0, oe, dr};  // no parity or break

    // interrupt priority rls, rda, thre
    assign thre_int = ier[1] && thre;

    always_comb begin
        if (ier[2] && (oe || fe))
            iir_code = RLS;
        else if (ier[0] && dr)
            iir_code = RDA;
        else if (thre_pnd && ier[1])
            iir_code = THRE;
        else
            iir_code = NONE;
    end

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            thre_int_d <= 1'b0;
            thre_pnd   <= 1'b0;
            irq        <= 1'b0;
        end else begin
            thre_int_d <= thre_int;
            if (wr_thr || (rd_iir && iir_code == THRE))
                thre_pnd <= 1'b0;  // acknowledged
            else if (thre_int && !thre_int_d)
                thre_pnd <= 1'b1;
            else
                thre_pnd <= thre_pnd && ier[1];  // dropped when masked
            irq <= (iir_code != NONE);
        end
    end

    // read mux
    always_comb begin
        case (reg_off)
            RB_TH_DLL: rd_byte = dlab ? dl[`UART_DATA_W-1:0] : rbr;
            IE_DLM:    rd_byte = dlab ? dl[`UART_DIV_W-1:`UART_DATA_W] : {5'b0, ier};
            II:        rd_byte = {4'b1100, iir_code};
            LC:        rd_byte = lcr;
            MC:        rd_byte = {3'b0, loopback, 4'b0};
            LS:        rd_byte = lsr;
            SR:        rd_byte = scratch;
            default:   rd_byte = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reg_read)
            prdata <= addr_valid ? {24'b0, rd_byte} : '0;  // held through access phase
    end

    // dr only drops two edges after an apb read at word offset 0 with dlab clear
    a_dr_clear: assert property (@(posedge clk) disable iff (!nreset)
        $fell(dr) |-> $past(psel && !penable && !pwrite && !dlab
                            && paddr[`UART_ADDR_W-1:2] == '0, 2));

endmodule

// File: uart_rx.sv
`timescale 1ns/1ns
`include "uart_defs.svh"

module uart_rx import uart_reg_pkg::*, uart_line_pkg::*; (
    input  logic       clk,
    input  logic       nreset,
    input  logic       baud_tick,     // 16x bit rate
    input  logic       rx_serial,     // synced line or loopback
    output logic       rx_valid,      // one cycle per frame
    output logic       rx_frame_err,  // stop sample was low
    output uart_byte_t rx_data
);

    uart_rx_state_e state;
    uart_byte_t     shift_q;   // msb filled first, lsb ends up at bit 0
    uart_tick_cnt_t tick_cnt;
    uart_bit_cnt_t  bit_idx;
    logic           mid_start;
    logic           bit_done;

    // half a bit after the falling edge was seen
    assign mid_start = baud_tick && (tick_cnt == uart_tick_cnt_t'(`UART_OVERSAMPLE / 2 - 1));
    // one full bit after the previous sample
    assign bit_done  = baud_tick && (tick_cnt == uart_tick_cnt_t'(`UART_OVERSAMPLE - 1));

    assign rx_data = shift_q;  // stable from stop bit to next data bit

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            state        <= RX_IDLE;
            tick_cnt     <= '0;
            bit_idx      <= '0;
            rx_valid     <= 1'b0;
            rx_frame_err <= 1'b0;
        end else begin
            rx_valid <= 1'b0;  // pulse

            case (state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    if (baud_tick && !rx_serial)
                        state <= RX_START;  // possible start bit
                end
                RX_START: begin
                    if (mid_start) begin
                        tick_cnt <= '0;  // realign on bit centre
                        bit_idx  <= '0;
                        if (rx_serial)
                            state <= RX_IDLE;  // glitch, back off
                        else
                            state <= RX_DATA;
                    end else if (baud_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (baud_tick)
                        tick_cnt <= tick_cnt + 1'b1;  // wraps on the sample tick
                    if (bit_done) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == uart_bit_cnt_t'(`UART_DATA_W - 1))
                            state <= RX_STOP;
                    end
                end
                default: begin  // stop bit
                    if (baud_tick)
                        tick_cnt <= tick_cnt + 1'b1;
                    if (bit_done) begin
                        rx_valid     <= 1'b1;
                        rx_frame_err <= !rx_serial;
                        state        <= RX_IDLE;  // rest of stop bit is idle time
                    end
                end
            endcase
        end
    end

    // lsb first on the wire
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_done)
            shift_q <= {rx_serial, shift_q[`UART_DATA_W-1:1]};
    end

    // dr/oe logic counts frames by pulses
    a_valid_pulse: assert property (@(posedge clk) disable iff (!nreset)
        rx_valid |=> !rx_valid);

endmodule

// File: uart_tx.sv
`timescale 1ns/1ns
`include "uart_defs.svh"

module uart_tx import uart_reg_pkg::*, uart_line_pkg::*; (
    input  logic       clk,
    input  logic       nreset,
    input  logic       baud_tick,  // 16x bit rate
    input  logic       tx_load,    // holding reg handed over
    input  uart_byte_t tx_data,
    output logic       tx_serial,  // line out, idles high
    output logic       tx_busy
);

    uart_tx_state_e state;
    uart_byte_t     shift_q;   // lsb goes out next
    uart_tick_cnt_t tick_cnt;  // ticks into current bit
    uart_bit_cnt_t  bit_idx;
    logic           bit_done;

    // last tick of a bit
    assign bit_done = baud_tick && (tick_cnt == uart_tick_cnt_t'(`UART_OVERSAMPLE - 1));

    assign tx_busy = (state != TX_IDLE);

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            state     <= TX_IDLE;
            tick_cnt  <= '0;
            bit_idx   <= '0;
            tx_serial <= 1'b1;
        end else begin
            if (state == TX_IDLE)
                tick_cnt <= '0;  // bit timing starts at load
            else if (baud_tick)
                tick_cnt <= tick_cnt + 1'b1;  // wraps every bit

            case (state)
                TX_IDLE: begin
                    if (tx_load)
                        state <= TX_START;
                end
                TX_START: begin
                    if (bit_done) begin
                        state   <= TX_DATA;
                        bit_idx <= '0;
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == uart_bit_cnt_t'(`UART_DATA_W - 1))
                            state <= TX_STOP;
                    end
                end
                default: begin  // stop bit
                    if (bit_done)
                        state <= TX_IDLE;
                end
            endcase

            // registered line driver, no glitches on the pin
            case (state)
                TX_START: tx_serial <= 1'b0;
                TX_DATA:  tx_serial <= shift_q[0];
                default:  tx_serial <= 1'b1;  // stop and idle
            endcase
        end
    end

    // data shifter
    always_ff @(posedge clk) begin
        if (tx_load && state == TX_IDLE)
            shift_q <= tx_data;
        else if (state == TX_DATA && bit_done)
            shift_q <= shift_q >> 1;
    end

    // register block has to hold off until the frame is out
    a_no_load_busy: assert property (@(posedge clk) disable iff (!nreset)
        tx_load |-> !tx_busy);

endmodule

// File: uart_line_pkg.sv
`include "uart_defs.svh"

package uart_line_pkg;

    // counts baud ticks inside one bit
    typedef logic [$clog2(`UART_OVERSAMPLE)-1:0] uart_tick_cnt_t;

    // which data bit is on the line
    typedef logic [$clog2(`UART_DATA_W)-1:0] uart_bit_cnt_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } uart_tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,   // waiting for mid start bit
        RX_DATA,
        RX_STOP
    } uart_rx_state_e;

endpackage

// File: uart_reg_pkg.sv
`include "uart_defs.svh"

package uart_reg_pkg;

    // one character as seen on the data bus
    typedef logic [`UART_DATA_W-1:0] uart_byte_t;

    // dlm:dll as one value
    typedef logic [`UART_DIV_W-1:0] uart_div_t;

    // word offset taken from paddr[4:2]
    typedef enum logic [2:0] {
        RB_TH_DLL = 3'd0,   // rbr on read, thr on write, dll when dlab set
        IE_DLM    = 3'd1,   // ier or dlm
        II        = 3'd2,   // read only
        LC        = 3'd3,
        MC        = 3'd4,   // loopback bit only
        LS        = 3'd5,
        SR        = 3'd7    // scratch
    } uart_reg_e;

    // interrupt id in iir[3:0]
    // bit 0 low while something is pending
    typedef enum logic [3:0] {
        NONE = 4'h1,
        THRE = 4'h2,
        RDA  = 4'h4,
        RLS  = 4'h6
    } uart_iir_e;

endpackage

// File: uart_defs.svh
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// one character, 8n1 only
`define UART_DATA_W 8

// dll plus dlm
`define UART_DIV_W 16

// baud ticks per serial bit
`define UART_OVERSAMPLE 16

// byte address on apb, word offset in bits 4:2
`define UART_ADDR_W 8

// 8 data bits, 1 stop, dlab clear
`define UART_LCR_RESET 8'h03

`endif
